// ==== flash_dump_pkg.sv ====
// package: flash address union, read command, line characters, line length
package flash_dump_pkg;

	// ---------------------------------------------------------------------------
	// widths
	// ---------------------------------------------------------------------------
	localparam int ADDR_BITS = 24;
	localparam int WORD_BITS = 8;

	// flash address: counted as one word, printed as three bytes
	typedef union packed {
		logic [ADDR_BITS-1:0] word;
		struct packed {
			logic [WORD_BITS-1:0] hi;
			logic [WORD_BITS-1:0] mid;
			logic [WORD_BITS-1:0] lo;
		} bytes;
	} flash_addr_u;

	// ---------------------------------------------------------------------------
	// flash command
	// ---------------------------------------------------------------------------
	localparam logic [WORD_BITS-1:0] CMD_READ = 8'h03;   // plain read, no dummy byte

	// ---------------------------------------------------------------------------
	// line format
	// ---------------------------------------------------------------------------
	localparam logic [WORD_BITS-1:0] CHR_SEP   = 8'h5f;  // '_'
	localparam logic [WORD_BITS-1:0] CHR_SPACE = 8'h20;  // ' '
	localparam logic [WORD_BITS-1:0] CHR_CR    = 8'h0d;
	localparam logic [WORD_BITS-1:0] CHR_LF    = 8'h0a;
	localparam logic [WORD_BITS-1:0] CHR_ZERO  = 8'h30;  // '0'
	localparam logic [WORD_BITS-1:0] CHR_ONE   = 8'h31;  // '1'

	// 3*8 address bits + 2 separators + space + raw byte + space + 8 bits + cr + lf
	localparam int LINE_CHARS = 39;

endpackage

// ==== serial_async_tx.sv ====
// module serial_async_tx: 8N1 UART transmitter with req/ack handshake
`timescale 1ns/1ps

module serial_async_tx import flash_dump_pkg::*; #(
	parameter int CLKS_PER_BIT = 234
) (
	input  logic                 clk27,
	input  logic                 rst,
	input  logic                 tx_req,
	input  logic [WORD_BITS-1:0] tx_char,
	output logic                 tx_ack,
	output logic                 serial_tx,
	output logic                 busy
);

	localparam int CNT_W   = $clog2(CLKS_PER_BIT + 1);
	localparam int FRAME_W = WORD_BITS + 2;   // start + data + stop

	logic [FRAME_W-1:0]         frame;      // lsb is on the line
	logic [CNT_W-1:0]           baud_cnt;
	logic [$clog2(FRAME_W)-1:0] bit_cnt;
	logic                       baud_tick;

	assign baud_tick = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign serial_tx = frame[0];

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			frame    <= '1;   // idle line is high
			baud_cnt <= '0;
			bit_cnt  <= '0;
			busy     <= 1'b0;
			tx_ack   <= 1'b0;
		end else if (busy) begin
			if (baud_tick) begin
				baud_cnt <= '0;
				frame    <= {1'b1, frame[FRAME_W-1:1]};   // refill with stop level
				bit_cnt  <= bit_cnt + 1'b1;
				if (bit_cnt == ($clog2(FRAME_W))'(FRAME_W - 1)) begin
					// stop bit done
					busy   <= 1'b0;
					tx_ack <= 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end else if (tx_ack) begin
			if (!tx_req)
				tx_ack <= 1'b0;   // close the handshake
		end else if (tx_req) begin
			frame    <= {1'b1, tx_char, 1'b0};
			baud_cnt <= '0;
			bit_cnt  <= '0;
			busy     <= 1'b1;
		end
	end

	// ---------------------------------------------------------------------------
	// checks
	// ---------------------------------------------------------------------------

	// requester must keep req up for the whole frame
	ack_needs_req: assert property (@(posedge clk27) disable iff (rst)
		$rose(tx_ack) |-> tx_req && $past(tx_req))
		else $error("tx_ack rose without a pending tx_req");

endmodule

// ==== flash_serial.sv ====
// module flash_serial: SPI mode-0 flash reader, read command + address + one byte
`timescale 1ns/1ps

module flash_serial import flash_dump_pkg::*; #(
	parameter int SCK_HALF = 2
) (
	input  logic                 clk27,
	input  logic                 rst,
	input  logic                 rd_req,
	input  flash_addr_u          rd_addr,
	output logic                 rd_ack,
	output logic [WORD_BITS-1:0] rd_data,
	output logic                 busy,
	output logic                 flash_clk,
	output logic                 flash_sel,
	output logic                 flash_out,
	input  logic                 flash_in
);

	localparam int OUT_BITS = WORD_BITS + ADDR_BITS;   // command and address
	localparam int ALL_BITS = OUT_BITS + WORD_BITS;    // plus the data byte
	localparam int HALF_W   = $clog2(SCK_HALF + 1);
	localparam int BIT_W    = $clog2(ALL_BITS + 1);

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_SETUP = 3'd1;
	localparam logic [2:0] S_XFER  = 3'd2;
	localparam logic [2:0] S_HOLD  = 3'd3;
	localparam logic [2:0] S_ACK   = 3'd4;

	logic [2:0]           state;
	logic [HALF_W-1:0]    half_cnt;
	logic [BIT_W-1:0]     bit_cnt;    // falling sck edges so far
	logic [OUT_BITS-1:0]  out_sr;
	logic [WORD_BITS-1:0] in_sr;
	logic                 half_done;

	assign half_done = (half_cnt == HALF_W'(SCK_HALF - 1));
	assign flash_out = out_sr[OUT_BITS-1];   // msb first
	assign rd_data   = in_sr;
	assign busy      = (state != S_IDLE);

	// ---------------------------------------------------------------------------
	// transaction control
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state     <= S_IDLE;
			half_cnt  <= '0;
			bit_cnt   <= '0;
			out_sr    <= '0;
			flash_clk <= 1'b0;
			flash_sel <= 1'b1;
			rd_ack    <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (rd_req && !rd_ack) begin
					out_sr    <= {CMD_READ, rd_addr.word};
					flash_sel <= 1'b0;   // first bit already on the pin
					state     <= S_SETUP;
				end
				S_SETUP: begin
					half_cnt <= '0;
					bit_cnt  <= '0;
					state    <= S_XFER;
				end
				S_XFER: begin
					if (half_done) begin
						half_cnt  <= '0;
						flash_clk <= ~flash_clk;
						if (flash_clk) begin
							// falling edge: next bit out
							out_sr  <= {out_sr[OUT_BITS-2:0], 1'b0};
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_W'(ALL_BITS - 1))
								state <= S_HOLD;
						end
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				S_HOLD: begin
					flash_sel <= 1'b1;
					rd_ack    <= 1'b1;
					state     <= S_ACK;
				end
				S_ACK: if (!rd_req) begin
					rd_ack <= 1'b0;
					state  <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// sample on the rising edge once the address is out
	always_ff @(posedge clk27) begin
		if (state == S_XFER && half_done && !flash_clk && bit_cnt >= BIT_W'(OUT_BITS))
			in_sr <= {in_sr[WORD_BITS-2:0], flash_in};
	end

	// sck parked low whenever the flash is deselected
	sck_idle_low: assert property (@(posedge clk27) disable iff (rst)
		flash_sel |-> !flash_clk)
		else $error("flash_clk high while flash_sel is high");

endmodule

// ==== key_toggle.sv ====
// module key_toggle: key synchroniser, debouncer and pause toggle
`timescale 1ns/1ps

module key_toggle #(
	parameter int STABLE_CYCLES = 270_000
) (
	input  logic clk27,
	input  logic rst,
	input  logic key,      // active low
	output logic paused
);

	localparam int CNT_W = $clog2(STABLE_CYCLES + 1);

	logic             key_s1;
	logic             key_s2;
	logic             key_lvl;   // debounced level, still active low
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			key_s1     <= 1'b1;   // released
			key_s2     <= 1'b1;
			key_lvl    <= 1'b1;
			stable_cnt <= '0;
			paused     <= 1'b0;
		end else begin
			key_s1 <= key;
			key_s2 <= key_s1;

			if (key_s2 == key_lvl) begin
				stable_cnt <= '0;   // bounce or no change
			end else if (stable_cnt == CNT_W'(STABLE_CYCLES - 1)) begin
				stable_cnt <= '0;
				key_lvl    <= key_s2;
				if (!key_s2)
					paused <= ~paused;   // one flip per press
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== dump_sequencer.sv ====
// module dump_sequencer: read pacing, line formatting and address advance
`timescale 1ns/1ps

module dump_sequencer import flash_dump_pkg::*; #(
	parameter int WAIT_CYCLES = 5_400_000
) (
	input  logic                 clk27,
	input  logic                 rst,
	input  logic                 paused,
	output logic                 rd_req,
	output flash_addr_u          rd_addr,
	input  logic                 rd_ack,
	input  logic [WORD_BITS-1:0] rd_data,
	output logic                 tx_req,
	output logic [WORD_BITS-1:0] tx_char,
	input  logic                 tx_ack
);

	localparam int WAIT_W = $clog2(WAIT_CYCLES + 1);
	localparam int BIT_W  = $clog2(WORD_BITS);
	localparam int REQ_W  = $clog2(LINE_CHARS + 1);

	localparam logic [3:0] S_WAIT    = 4'd0;
	localparam logic [3:0] S_READ    = 4'd1;
	localparam logic [3:0] S_ADDR    = 4'd2;    // first char state
	localparam logic [3:0] S_SEP     = 4'd3;
	localparam logic [3:0] S_SPACE_A = 4'd4;
	localparam logic [3:0] S_DATA    = 4'd5;
	localparam logic [3:0] S_SPACE_D = 4'd6;
	localparam logic [3:0] S_BITS    = 4'd7;
	localparam logic [3:0] S_CR      = 4'd8;
	localparam logic [3:0] S_LF      = 4'd9;    // last char state
	localparam logic [3:0] S_NEXT    = 4'd10;

	logic [3:0]           state;
	logic [WAIT_W-1:0]    wait_cnt;
	logic [BIT_W-1:0]     bit_cnt;     // wraps after the last bit of a group
	logic [1:0]           grp;         // address byte: hi, mid, lo
	logic [WORD_BITS-1:0] data_q;
	logic [WORD_BITS-1:0] addr_byte;
	logic [BIT_W-1:0]     msb_idx;
	logic                 char_state;
	logic                 tx_done;
	logic                 tx_req_q;
	logic [REQ_W-1:0]     req_cnt;

	assign char_state = (state >= S_ADDR) && (state <= S_LF);
	assign tx_done    = tx_req && tx_ack;
	assign msb_idx    = BIT_W'(WORD_BITS - 1) - bit_cnt;

	// ---------------------------------------------------------------------------
	// character select
	// ---------------------------------------------------------------------------
	always_comb begin
		case (grp)
			2'd0:    addr_byte = rd_addr.bytes.hi;
			2'd1:    addr_byte = rd_addr.bytes.mid;
			default: addr_byte = rd_addr.bytes.lo;
		endcase
		case (state)
			S_ADDR:              tx_char = addr_byte[msb_idx] ? CHR_ONE : CHR_ZERO;
			S_SEP:               tx_char = CHR_SEP;
			S_DATA:              tx_char = data_q;   // raw byte
			S_BITS:              tx_char = data_q[msb_idx] ? CHR_ONE : CHR_ZERO;
			S_CR:                tx_char = CHR_CR;
			S_LF:                tx_char = CHR_LF;
			default:             tx_char = CHR_SPACE;
		endcase
	end

	// ---------------------------------------------------------------------------
	// sequencing
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state    <= S_WAIT;   // settling time after reset
			wait_cnt <= '0;
			bit_cnt  <= '0;
			grp      <= '0;
			rd_req   <= 1'b0;
			rd_addr  <= '0;
			tx_req   <= 1'b0;
		end else begin
			// one char per req/ack cycle, wait for the uart to drop ack
			if (char_state) begin
				if (!tx_req && !tx_ack)
					tx_req <= 1'b1;
				else if (tx_done)
					tx_req <= 1'b0;
			end

			case (state)
				S_WAIT: begin
					if (paused) begin
						wait_cnt <= '0;
					end else if (wait_cnt == WAIT_W'(WAIT_CYCLES - 1)) begin
						wait_cnt <= '0;
						state    <= S_READ;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				S_READ: begin
					if (!rd_req && !rd_ack) begin
						rd_req <= 1'b1;
					end else if (rd_req && rd_ack) begin
						rd_req  <= 1'b0;
						bit_cnt <= '0;
						grp     <= '0;
						state   <= S_ADDR;
					end
				end
				S_ADDR: if (tx_done) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(WORD_BITS - 1))
						state <= (grp == 2'd2) ? S_SPACE_A : S_SEP;
				end
				S_SEP: if (tx_done) begin
					grp   <= grp + 1'b1;
					state <= S_ADDR;
				end
				S_SPACE_A: if (tx_done) state <= S_DATA;
				S_DATA:    if (tx_done) state <= S_SPACE_D;
				S_SPACE_D: if (tx_done) state <= S_BITS;
				S_BITS: if (tx_done) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(WORD_BITS - 1))
						state <= S_CR;
				end
				S_CR: if (tx_done) state <= S_LF;
				S_LF: if (tx_done) state <= S_NEXT;
				S_NEXT: begin
					rd_addr.word <= rd_addr.word + 1'b1;   // wraps at 2^24
					wait_cnt     <= '0;
					state        <= S_WAIT;
				end
				default: state <= S_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk27) begin
		if (state == S_READ && rd_req && rd_ack)
			data_q <= rd_data;
	end

	// requests per line, for the line-length check
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			tx_req_q <= 1'b0;
			req_cnt  <= '0;
		end else begin
			tx_req_q <= tx_req;
			if (state == S_NEXT)
				req_cnt <= '0;
			else if (tx_req && !tx_req_q)
				req_cnt <= req_cnt + 1'b1;
		end
	end

	rd_req_held: assert property (@(posedge clk27) disable iff (rst)
		rd_req && !rd_ack |=> rd_req && $stable(rd_addr))
		else $error("rd_req or rd_addr changed before rd_ack");

	line_length: assert property (@(posedge clk27) disable iff (rst)
		state == S_NEXT |-> req_cnt == REQ_W'(LINE_CHARS))
		else $error("line did not have LINE_CHARS characters");

endmodule

// ==== flash_dump_top.sv ====
// module flash_dump_top: flash dump engine top level and LED drive
`timescale 1ns/1ps

module flash_dump_top import flash_dump_pkg::*; #(
	parameter int CLKS_PER_BIT  = 234,         // 115200 baud at 27 MHz
	parameter int SCK_HALF      = 2,
	parameter int WAIT_CYCLES   = 5_400_000,   // 200 ms
	parameter int STABLE_CYCLES = 270_000      // 10 ms
) (
	input  logic       clk27,
	input  logic       rst,
	input  logic       flash_in,
	input  logic       key,
	output logic       serial_tx,
	output logic       flash_clk,
	output logic       flash_sel,
	output logic       flash_out,
	output logic [2:0] led
);

	logic                 paused;
	logic                 rd_req;
	logic                 rd_ack;
	logic                 rd_busy;
	flash_addr_u          rd_addr;
	logic [WORD_BITS-1:0] rd_data;
	logic                 tx_req;
	logic                 tx_ack;
	logic                 tx_busy;
	logic [WORD_BITS-1:0] tx_char;

	// ---------------------------------------------------------------------------
	// blocks
	// ---------------------------------------------------------------------------
	key_toggle #(.STABLE_CYCLES(STABLE_CYCLES)) u_key (
		.clk27(clk27), .rst(rst), .key(key), .paused(paused)
	);

	dump_sequencer #(.WAIT_CYCLES(WAIT_CYCLES)) u_seq (
		.clk27(clk27), .rst(rst), .paused(paused),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data),
		.tx_req(tx_req), .tx_char(tx_char), .tx_ack(tx_ack)
	);

	flash_serial #(.SCK_HALF(SCK_HALF)) u_flash (
		.clk27(clk27), .rst(rst),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data),
		.busy(rd_busy),
		.flash_clk(flash_clk), .flash_sel(flash_sel),
		.flash_out(flash_out), .flash_in(flash_in)
	);

	serial_async_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
		.clk27(clk27), .rst(rst),
		.tx_req(tx_req), .tx_char(tx_char), .tx_ack(tx_ack),
		.serial_tx(serial_tx), .busy(tx_busy)
	);

	// leds are active low
	assign led[0] = ~paused;
	assign led[1] = ~rd_busy;   // flash read
	assign led[2] = ~tx_busy;   // uart sending

endmodule

// ==== tb_flash_model.sv ====
// module tb_flash_model: behavioural SPI mode-0 read flash with command and address checks
`timescale 1ns/1ps

module tb_flash_model (
	input  logic sck,
	input  logic sel,     // active low
	input  logic mosi,
	output logic miso,
	output logic error    // set on the first bad transaction
);

	localparam logic [7:0] READ_CMD = 8'h03;
	localparam logic [7:0] DATA_XOR = 8'ha5;
	localparam int         HDR_BITS = 32;   // command + 24-bit address
	localparam int         ALL_BITS = 40;

	logic [31:0] hdr_sr;
	logic [7:0]  out_byte;
	logic [23:0] exp_addr;
	int          rise_cnt;
	logic        active;
	logic        sck_q;      // pin levels before the last event
	logic        sel_q;

	// ---------------------------------------------------------------------------
	// one process follows both pins
	// ---------------------------------------------------------------------------
	initial begin
		miso     = 1'b0;
		error    = 1'b0;
		hdr_sr   = '0;
		out_byte = '0;
		exp_addr = '0;   // dump starts at address zero
		rise_cnt = 0;
		active   = 1'b0;
		sck_q    = 1'b0;
		sel_q    = 1'b1;
		forever begin
			@(sck or sel);

			// select falls, a new transaction
			if (sel_q === 1'b1 && sel === 1'b0) begin
				rise_cnt = 0;
				active   = 1'b1;
			end

			// select rises, count the clocks
			if (sel_q === 1'b0 && sel === 1'b1 && active) begin
				active = 1'b0;
				clocks_ok: assert (rise_cnt == ALL_BITS) else begin
					$display("Mismatch at %0t: flash select rose after %0d clocks, expected %0d",
						$time, rise_cnt, ALL_BITS);
					error = 1'b1;
				end
			end

			// mode 0: sample on the rising edge
			if (sck_q === 1'b0 && sck === 1'b1 && sel === 1'b0) begin
				if (rise_cnt < HDR_BITS)
					hdr_sr = {hdr_sr[30:0], mosi};
				rise_cnt = rise_cnt + 1;
			end

			// data changes on the falling edge
			if (sck_q === 1'b1 && sck === 1'b0 && sel === 1'b0) begin
				if (rise_cnt == HDR_BITS) begin
					cmd_ok: assert (hdr_sr[31:24] == READ_CMD) else begin
						$display("Mismatch at %0t: flash command %02h, expected %02h",
							$time, hdr_sr[31:24], READ_CMD);
						error = 1'b1;
					end
					addr_ok: assert (hdr_sr[23:0] == exp_addr) else begin
						$display("Mismatch at %0t: flash address %06h, expected %06h",
							$time, hdr_sr[23:0], exp_addr);
						error = 1'b1;
					end
					out_byte = hdr_sr[7:0] ^ DATA_XOR;
					exp_addr = exp_addr + 1'b1;
				end
				if (rise_cnt >= HDR_BITS && rise_cnt < ALL_BITS)
					miso = out_byte[ALL_BITS - 1 - rise_cnt];   // msb first
			end

			sck_q = sck;
			sel_q = sel;
		end
	end

endmodule

// ==== tb_flash_dump.sv ====
// module tb_flash_dump: testbench with clock, reset, UART receiver, directed tests, watchdog
`timescale 1ns/1ps

module tb_flash_dump;

	localparam int CLKS_PER_BIT  = 8;
	localparam int SCK_HALF      = 2;
	localparam int WAIT_CYCLES   = 50;
	localparam int STABLE_CYCLES = 20;
	localparam int LINE_CHARS    = 39;

	localparam int LINE_BOUND   = WAIT_CYCLES + 80 * SCK_HALF + 8 * CLKS_PER_BIT;
	localparam int CHAR_BOUND   = 3 * CLKS_PER_BIT;
	localparam int LINE_CYCLES  = LINE_CHARS * 10 * CLKS_PER_BIT + 400;
	localparam int PAUSE_CYCLES = 5 * WAIT_CYCLES + 4 * STABLE_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * (8 * LINE_CYCLES + 2 * PAUSE_CYCLES);

	localparam logic [7:0] CHR_SEP   = 8'h5f;
	localparam logic [7:0] CHR_SPACE = 8'h20;
	localparam logic [7:0] CHR_CR    = 8'h0d;
	localparam logic [7:0] CHR_LF    = 8'h0a;
	localparam logic [7:0] CHR_ZERO  = 8'h30;
	localparam logic [7:0] CHR_ONE   = 8'h31;

	logic       clk27;
	logic       rst;
	logic       key;
	logic       serial_tx;
	logic       flash_clk;
	logic       flash_sel;
	logic       flash_out;
	logic       flash_in;
	logic       model_error;
	logic [2:0] led;

	flash_dump_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT), .SCK_HALF(SCK_HALF),
		.WAIT_CYCLES(WAIT_CYCLES), .STABLE_CYCLES(STABLE_CYCLES)
	) uut (
		.clk27(clk27), .rst(rst), .flash_in(flash_in), .key(key),
		.serial_tx(serial_tx), .flash_clk(flash_clk), .flash_sel(flash_sel),
		.flash_out(flash_out), .led(led)
	);

	tb_flash_model flash_mem (
		.sck(flash_clk), .sel(flash_sel), .mosi(flash_out), .miso(flash_in),
		.error(model_error)
	);

	initial begin
		clk27 = 1'b0;
		forever #50 clk27 = ~clk27;   // 10 MHz stand-in for 27 MHz
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// ---------------------------------------------------------------------------
	// line format and UART receiver
	// ---------------------------------------------------------------------------
	function automatic logic [7:0] expected_char(input logic [23:0] addr, input int idx);
		logic [7:0] data;
		int         grp;
		data = addr[7:0] ^ 8'ha5;   // model data rule
		if (idx < 26) begin
			grp = idx / 9;
			if (idx % 9 == 8)
				return CHR_SEP;
			return addr[23 - grp * 8 - idx % 9] ? CHR_ONE : CHR_ZERO;
		end
		case (idx)
			26, 28:  return CHR_SPACE;
			27:      return data;
			37:      return CHR_CR;
			38:      return CHR_LF;
			default: return data[36 - idx] ? CHR_ONE : CHR_ZERO;   // bit field, msb first
		endcase
	endfunction

	task automatic receive_char(input int bound, output logic [7:0] c);
		int waited;
		waited = 0;
		@(negedge clk27);
		while (serial_tx) begin
			waited++;
			if (waited > bound)
				abort_run($sformatf("no UART start bit within %0d cycles at %0t", bound, $time));
			@(negedge clk27);
		end
		repeat (CLKS_PER_BIT / 2) @(negedge clk27);   // middle of start bit
		assert (serial_tx === 1'b0)
			else abort_run($sformatf("start bit shorter than half a bit at %0t", $time));
		assert (led[2] === 1'b0)
			else abort_run($sformatf("Mismatch at %0t: UART LED off during a start bit", $time));
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk27);
			c[i] = serial_tx;   // lsb first
		end
		repeat (CLKS_PER_BIT) @(negedge clk27);
		assert (serial_tx === 1'b1)
			else abort_run($sformatf("Mismatch at %0t: stop bit is low", $time));
	endtask

	task automatic check_line(input logic [23:0] addr);
		logic [7:0] got;
		logic [7:0] exp;
		for (int i = 0; i < LINE_CHARS; i++) begin
			receive_char((i == 0) ? LINE_BOUND : CHAR_BOUND, got);
			exp = expected_char(addr, i);
			assert (got === exp) else abort_run($sformatf(
				"Mismatch at %0t: address %06h char %0d is %02h, expected %02h",
				$time, addr, i, got, exp));
		end
		$display("line for address %06h received at %0t", addr, $time);
	endtask

	// ---------------------------------------------------------------------------
	// directed tests
	// ---------------------------------------------------------------------------
	task automatic check_idle_pins(input string where);
		assert (serial_tx === 1'b1 && flash_sel === 1'b1 && flash_clk === 1'b0 && led === 3'b111)
			else abort_run($sformatf(
				"Mismatch at %0t: %s serial_tx %b flash_sel %b flash_clk %b led %b",
				$time, where, serial_tx, flash_sel, flash_clk, led));
	endtask

	task automatic test_reset_state();
		repeat (10) begin
			@(negedge clk27);
			check_idle_pins("in reset");
		end
		@(posedge clk27);
		rst <= 1'b0;
		repeat (3) begin
			@(negedge clk27);
			check_idle_pins("after reset");
		end
	endtask

	task automatic press_key(input int len);
		@(posedge clk27);
		key <= 1'b0;   // active low
		repeat (len) @(posedge clk27);
		key <= 1'b1;
	endtask

	task automatic check_pause_led(input logic exp_paused);
		@(negedge clk27);
		assert (led[0] === ~exp_paused) else abort_run($sformatf(
			"Mismatch at %0t: pause LED %b, paused should be %b", $time, led[0], exp_paused));
	endtask

	task automatic quiet_window(input int cycles);
		repeat (cycles) begin
			@(negedge clk27);
			assert (serial_tx === 1'b1) else abort_run($sformatf(
				"UART started a character at %0t while the dump was paused", $time));
		end
	endtask

	task automatic test_pause_resume();
		press_key(STABLE_CYCLES + 8 + ($urandom % 23));
		check_pause_led(1'b1);
		quiet_window(5 * WAIT_CYCLES);
		press_key(STABLE_CYCLES + 8 + ($urandom % 23));
		check_pause_led(1'b0);
		check_line(24'd4);   // resumes at the next address
	endtask

	task automatic test_key_glitch();
		press_key(2 + ($urandom % (STABLE_CYCLES - 6)));
		check_pause_led(1'b0);
		check_line(24'd5);
		check_line(24'd6);
	endtask

	// ---------------------------------------------------------------------------
	// run control
	// ---------------------------------------------------------------------------
	always @(posedge model_error)
		abort_run("flash model saw a bad SPI transaction");

	// read LED lit while the flash is selected
	always @(negedge clk27) begin
		if (flash_sel === 1'b0)
			assert (led[1] === 1'b0) else abort_run($sformatf(
				"Mismatch at %0t: read LED off while the flash is selected", $time));
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk27);
		abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		rst    = 1'b1;
		key    = 1'b1;   // released
		void'($urandom(80));
		test_reset_state();
		check_line(24'd0);
		for (int a = 1; a <= 3; a++)
			check_line(24'(a));
		test_pause_resume();
		test_key_glitch();
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== Makefile ====
# Verilator flow for the flash dump engine

TB_TOP  = tb_flash_dump
RTL_TOP = flash_dump_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(RTL_TOP)
	verilator --lint-only --timing --assert -f project.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
flash_dump_pkg.sv
serial_async_tx.sv
flash_serial.sv
key_toggle.sv
dump_sequencer.sv
flash_dump_top.sv
tb_flash_model.sv
tb_flash_dump.sv
